// File: common/pcs_consts.svh
`ifndef PCS_CONSTS_SVH
`define PCS_CONSTS_SVH

// Word and block widths
`define PCS_DATA_W      64
`define PCS_CTRL_W      8
`define PCS_BYTE_W      8
`define PCS_BLOCK_W     66
`define PCS_TAGGED_W    67
`define PCS_SH_W        2

// Control block fields
`define PCS_TYPE_W      8
`define PCS_CODE_W      7

// Sync headers
`define PCS_SH_DATA     2'b01
`define PCS_SH_CTRL     2'b10

// Block type of a block made only of control characters
`define PCS_TYPE_CTRL   8'h1E

// Seven-bit control codes
`define PCS_CODE_IDLE   7'h00
`define PCS_CODE_ERROR  7'h1E

// Idle character as it shows up on the XGMII side
`define PCS_IDLE_XGMII  8'h07

// Scrambler, polynomial 1 + x^39 + x^58
`define PCS_SCR_W       58
`define PCS_SCR_TAP     38
`define PCS_SEED        58'h0

`endif

// File: common/pcs_pkg.sv
`include "pcs_consts.svh"

package pcs_pkg;

	// Data block layout, header then the eight data bytes
	typedef struct packed
	{
		logic [`PCS_SH_W-1:0]   sh;
		logic [`PCS_DATA_W-1:0] payload;
	} data_view_t;

	// Control block layout
	// Block type sits right below the header, codes fill the rest
	typedef struct packed
	{
		logic [`PCS_SH_W-1:0]                    sh;
		logic [`PCS_TYPE_W-1:0]                  block_type;
		logic [`PCS_CTRL_W-1:0][`PCS_CODE_W-1:0] codes;
	} ctrl_view_t;

	// One 66-bit coded block seen either way
	// Both views keep the sync header in the top two bits
	typedef union packed
	{
		data_view_t data_view;
		ctrl_view_t ctrl_view;
	} block_t;

endpackage

// File: source/pcs_encoder.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module pcs_encoder
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  logic                   i_valid,
	input  logic                   i_tag,
	input  logic [`PCS_DATA_W-1:0] i_data,
	input  logic [`PCS_CTRL_W-1:0] i_ctrl,

	output pcs_pkg::block_t        o_block,
	output logic                   o_valid,
	output logic                   o_tag
);

	import pcs_pkg::*;

	// One flag per byte lane, high when that lane holds the idle character
	logic [`PCS_CTRL_W-1:0] byte_is_idle;

	logic    all_data;
	logic    all_idle;
	block_t  block_next;

	// Per-lane idle compare
	always_comb
	begin
		for (int lane = 0; lane < `PCS_CTRL_W; lane++)
		begin
			byte_is_idle[lane] =
				(i_data[lane*`PCS_BYTE_W +: `PCS_BYTE_W] == `PCS_IDLE_XGMII);
		end
	end

	// No control flags at all means a plain data block
	assign all_data = (i_ctrl == '0);

	// Idle block needs every lane flagged and every lane carrying idle
	assign all_idle = (&i_ctrl) && (&byte_is_idle);

	// Block formation
	always_comb
	begin
		block_next = '0;
		if (all_data)
		begin
			block_next.data_view.sh      = `PCS_SH_DATA;
			block_next.data_view.payload = i_data;
		end
		else
		begin
			block_next.ctrl_view.sh         = `PCS_SH_CTRL;
			block_next.ctrl_view.block_type = `PCS_TYPE_CTRL;
			for (int lane = 0; lane < `PCS_CTRL_W; lane++)
			begin
				// Anything other than a clean idle word is reported as error
				if (all_idle)
					block_next.ctrl_view.codes[lane] = `PCS_CODE_IDLE;
				else
					block_next.ctrl_view.codes[lane] = `PCS_CODE_ERROR;
			end
		end
	end

	// Output stage, valid and tag
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_tag   <= 1'b0;
		end
		else if (i_enable)
		begin
			o_valid <= i_valid;
			o_tag   <= i_tag;
		end
		else
		begin
			// Stalled cycle, nothing new goes out
			o_valid <= 1'b0;
		end
	end

	// Output stage, coded block
	always_ff @(posedge i_clock)
	begin
		if (i_enable)
			o_block <= block_next;
	end

endmodule

// File: scrambler/scrambler.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module scrambler
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  logic                     i_bypass,
	input  logic                     i_tag,
	input  logic                     i_idle_pattern_mode,
	input  pcs_pkg::block_t          i_block,

	output logic [`PCS_TAGGED_W-1:0] o_data,
	output logic                     o_valid
);

	import pcs_pkg::*;

	// Low feedback tap as seen from the bottom of the state
	// Bits enter at the top, so x^39 lands on index 58-1-38
	localparam int TAP_LOW = `PCS_SCR_W - 1 - `PCS_SCR_TAP;

	block_t                 idle_block;
	block_t                 source_block;
	block_t                 scrambled_block;
	logic                   bypass;
	logic                   out_bit;
	logic [`PCS_SCR_W-1:0]  scrambler_state;
	logic [`PCS_SCR_W-1:0]  scrambler_state_next;

	// Alignment markers go out raw as well
	assign bypass = i_bypass | i_tag;

	assign o_valid = i_valid;

	// Standard idle block, 2'b10 / 8'h1E / eight zero codes
	always_comb
	begin
		idle_block                      = '0;
		idle_block.ctrl_view.sh         = `PCS_SH_CTRL;
		idle_block.ctrl_view.block_type = `PCS_TYPE_CTRL;
		for (int lane = 0; lane < `PCS_CTRL_W; lane++)
		begin
			idle_block.ctrl_view.codes[lane] = `PCS_CODE_IDLE;
		end
	end

	// Idle-pattern mode swaps the whole input for the idle block
	assign source_block = i_idle_pattern_mode ? idle_block : i_block;

	// Payload scrambling, MSB first
	// Every output bit is fed straight back into the state
	always_comb
	begin
		scrambler_state_next = scrambler_state;
		out_bit              = 1'b0;

		scrambled_block.data_view.sh = source_block.data_view.sh;
		scrambled_block.data_view.payload = '0;

		for (int i = `PCS_DATA_W - 1; i >= 0; i--)
		begin
			out_bit = source_block.data_view.payload[i]
				^ scrambler_state_next[TAP_LOW]
				^ scrambler_state_next[0];
			scrambled_block.data_view.payload[i] = out_bit;
			scrambler_state_next =
				{out_bit, scrambler_state_next[`PCS_SCR_W-1:1]};
		end
	end

	// Tag bit always leads the output word
	always_comb
	begin
		if (bypass)
			o_data = {i_tag, i_block};
		else
			o_data = {i_tag, scrambled_block};
	end

	// State only moves on blocks that actually got scrambled
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			scrambler_state <= `PCS_SEED;
		else if (i_valid && !bypass)
			scrambler_state <= scrambler_state_next;
	end

endmodule

// File: source/pcs_tx.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module pcs_tx
(
	input  logic                     i_clock,
	input  logic                     i_reset,

	// XGMII-side word
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic [`PCS_DATA_W-1:0]   i_data,
	input  logic [`PCS_CTRL_W-1:0]   i_ctrl,

	// Alignment tag, travels with the word
	input  logic                     i_tag,

	// Mode controls, static levels
	input  logic                     i_bypass,
	input  logic                     i_idle_pattern_mode,

	// Tagged 66-bit block
	output logic [`PCS_TAGGED_W-1:0] o_data,
	output logic                     o_valid
);

	import pcs_pkg::*;

	// Encoder to scrambler, all registered in the encoder
	block_t enc_block;
	logic   enc_valid;
	logic   enc_tag;

	pcs_encoder u_encoder
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_valid  (i_valid),
		.i_tag    (i_tag),
		.i_data   (i_data),
		.i_ctrl   (i_ctrl),
		.o_block  (enc_block),
		.o_valid  (enc_valid),
		.o_tag    (enc_tag)
	);

	// Combinational to the outputs, so latency stays at one cycle
	scrambler u_scrambler
	(
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_valid             (enc_valid),
		.i_bypass            (i_bypass),
		.i_tag               (enc_tag),
		.i_idle_pattern_mode (i_idle_pattern_mode),
		.i_block             (enc_block),
		.o_data              (o_data),
		.o_valid             (o_valid)
	);

endmodule

// File: verification/pcs_tx_checker.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module pcs_tx_checker
(
	input logic                     i_clock,
	input logic                     i_reset,
	input logic                     i_valid,
	input logic                     i_bypass,
	input logic                     i_tag,
	input logic [`PCS_TAGGED_W-1:0] i_out_data,
	input logic                     i_out_valid,
	input logic [`PCS_SCR_W-1:0]    i_state
);

	int fail_count = 0;

	// Raw blocks must not move the scrambler
	state_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_valid && (i_bypass || i_tag)) |=> $stable(i_state))
	else
	begin
		$error("scrambler state moved after a tagged or bypassed block");
		fail_count++;
	end

	valid_after_reset: assert property (@(posedge i_clock)
		i_reset |=> !i_out_valid)
	else
	begin
		$error("o_valid high in the cycle after reset");
		fail_count++;
	end

	// Tag leads the output word
	tag_on_top: assert property (@(posedge i_clock) disable iff (i_reset)
		i_out_data[`PCS_TAGGED_W-1] == i_tag)
	else
	begin
		$error("o_data top bit differs from the tag");
		fail_count++;
	end

endmodule

bind scrambler pcs_tx_checker u_checker
(
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_valid     (i_valid),
	.i_bypass    (i_bypass),
	.i_tag       (i_tag),
	.i_out_data  (o_data),
	.i_out_valid (o_valid),
	.i_state     (scrambler_state)
);

// File: verification/pcs_tx_monitor.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module pcs_tx_monitor
(
	input logic                     i_clock,
	input logic                     i_reset,
	input logic                     i_valid,
	input logic [`PCS_TAGGED_W-1:0] i_data
);

	import pcs_pkg::*;

	// Expected words and the cycle each one is due in
	logic [`PCS_TAGGED_W-1:0] exp_data_q[$];
	int                       exp_cycle_q[$];

	logic [`PCS_TAGGED_W-1:0] expected;
	int                       due_cycle;

	int cycle_count   = 0;
	int error_count   = 0;
	int checked_count = 0;

	task automatic push_expected(input logic [`PCS_TAGGED_W-1:0] value, input int cycle);
		exp_data_q.push_back(value);
		exp_cycle_q.push_back(cycle);
	endtask

	function automatic int pending_count();
		return exp_data_q.size();
	endfunction

	// Name of a block from its header, for the error lines
	function automatic string block_kind(input block_t block);
		if (block.data_view.sh == `PCS_SH_DATA)
			return "data";
		else if (block.ctrl_view.sh == `PCS_SH_CTRL)
			return "control";
		else
			return "bad header";
	endfunction

	always @(posedge i_clock)
	begin
		cycle_count <= cycle_count + 1;
		if (!i_reset && $isunknown(i_valid))
		begin
			$display("error %0t o_valid is unknown outside reset", $time);
			error_count++;
		end
		else if (i_valid === 1'b1)
		begin
			if (exp_data_q.size() == 0)
			begin
				$display("error %0t o_valid went high with no block expected", $time);
				error_count++;
			end
			else
			begin
				expected  = exp_data_q.pop_front();
				due_cycle = exp_cycle_q.pop_front();
				checked_count++;
				if (i_data !== expected)
				begin
					$display("error %0t o_data expected %h got %h (%s block)", $time,
						expected, i_data, block_kind(expected[`PCS_BLOCK_W-1:0]));
					error_count++;
				end
				// One cycle from input to output
				if (due_cycle != cycle_count)
				begin
					$display("error %0t o_valid cycle expected %0d got %0d", $time,
						due_cycle, cycle_count);
					error_count++;
				end
			end
		end
	end

endmodule

// File: verification/tb_pcs_tx.sv
`timescale 1ns/1ps
`include "pcs_consts.svh"

module tb_pcs_tx;

	// Scrambler taps for x^39 and x^58, new bits enter at bit 57
	localparam int TAP_BIT   = 19;
	localparam int DRAIN_MAX = 20;

	logic                     i_clock;
	logic                     i_reset;
	logic                     i_enable;
	logic                     i_valid;
	logic [`PCS_DATA_W-1:0]   i_data;
	logic [`PCS_CTRL_W-1:0]   i_ctrl;
	logic                     i_tag;
	logic                     i_bypass;
	logic                     i_idle_pattern_mode;
	logic [`PCS_TAGGED_W-1:0] o_data;
	logic                     o_valid;

	int                    seed;
	int                    timeout_count;
	int                    total_errors;
	logic [`PCS_SCR_W-1:0] model_state;

	pcs_tx UUT
	(
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_enable            (i_enable),
		.i_valid             (i_valid),
		.i_data              (i_data),
		.i_ctrl              (i_ctrl),
		.i_tag               (i_tag),
		.i_bypass            (i_bypass),
		.i_idle_pattern_mode (i_idle_pattern_mode),
		.o_data              (o_data),
		.o_valid             (o_valid)
	);

	pcs_tx_monitor u_monitor
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (o_valid),
		.i_data  (o_data)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	function automatic logic [`PCS_TAGGED_W-1:0] expected_out(
		input  logic [`PCS_DATA_W-1:0] data,
		input  logic [`PCS_CTRL_W-1:0] ctrl,
		input  logic                   tag,
		input  logic                   bypass,
		input  logic                   idle_mode,
		input  logic [`PCS_SCR_W-1:0]  state_in,
		output logic [`PCS_SCR_W-1:0]  state_out);
		logic [`PCS_BLOCK_W-1:0] raw;
		logic [`PCS_BLOCK_W-1:0] src;
		logic [`PCS_BLOCK_W-1:0] scr;
		logic [`PCS_SCR_W-1:0]   s;
		logic                    all_idle;
		logic                    bit_out;
		all_idle = (ctrl == 8'hFF);
		for (int b = 0; b < 8; b++)
		begin
			if (data[b*8 +: 8] != 8'h07)
				all_idle = 1'b0;
		end
		if (ctrl == 8'h00)
			raw = {2'b01, data};
		else if (all_idle)
			raw = {2'b10, 8'h1E, 56'h0};
		else
			raw = {2'b10, 8'h1E, {8{7'h1E}}};
		state_out = state_in;
		if (bypass || tag)
			return {tag, raw};
		src = idle_mode ? {2'b10, 8'h1E, 56'h0} : raw;
		s   = state_in;
		scr = src;
		for (int i = 63; i >= 0; i--)
		begin
			bit_out = src[i] ^ s[TAP_BIT] ^ s[0];
			scr[i]  = bit_out;
			s       = {bit_out, s[57:1]};
		end
		state_out = s;
		return {tag, scr};
	endfunction

	function automatic logic [`PCS_DATA_W-1:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// Random control flags, one per byte lane
	function automatic logic [`PCS_CTRL_W-1:0] random_flags();
		logic [31:0] r;
		r = $random(seed);
		return r[`PCS_CTRL_W-1:0];
	endfunction

	// One word per falling edge, expected value queued when it will be accepted
	task automatic send_word(input logic [`PCS_DATA_W-1:0] data,
		input logic [`PCS_CTRL_W-1:0] ctrl, input logic tag,
		input logic enable, input logic valid);
		logic [`PCS_TAGGED_W-1:0] expected;
		logic [`PCS_SCR_W-1:0]    next_state;
		@(negedge i_clock);
		i_data   = data;
		i_ctrl   = ctrl;
		i_tag    = tag;
		i_enable = enable;
		i_valid  = valid;
		if (enable && valid)
		begin
			expected = expected_out(data, ctrl, tag, i_bypass, i_idle_pattern_mode,
				model_state, next_state);
			model_state = next_state;
			u_monitor.push_expected(expected, u_monitor.cycle_count + 1);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge i_clock);
		i_valid = 1'b0;
		i_tag   = 1'b0;
		while (u_monitor.pending_count() != 0 && waited < DRAIN_MAX)
		begin
			@(negedge i_clock);
			waited++;
		end
		if (u_monitor.pending_count() != 0)
		begin
			$display("timeout: %0d expected blocks never came out of the DUT",
				u_monitor.pending_count());
			timeout_count++;
		end
	endtask

	task automatic hold_reset(input int cycles);
		@(negedge i_clock);
		i_reset = 1'b1;
		repeat (cycles) @(negedge i_clock);
		i_reset     = 1'b0;
		model_state = `PCS_SEED;
	endtask

	initial
	begin
		logic [`PCS_CTRL_W-1:0] ctrl;
		logic [`PCS_DATA_W-1:0] data;
		seed                = 91844;
		timeout_count       = 0;
		model_state         = `PCS_SEED;
		i_reset             = 1'b1;
		i_enable            = 1'b0;
		i_valid             = 1'b0;
		i_data              = '0;
		i_ctrl              = '0;
		i_tag               = 1'b0;
		i_bypass            = 1'b0;
		i_idle_pattern_mode = 1'b0;
		repeat (8) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		// Plain data blocks
		repeat (40) send_word(random_word(), 8'h00, 1'b0, 1'b1, 1'b1);

		// Idle, error and data words mixed
		repeat (40)
		begin
			data = random_word();
			ctrl = random_flags();
			case ($random(seed) & 3)
				0: send_word({8{8'h07}}, 8'hFF, 1'b0, 1'b1, 1'b1);
				1: send_word(data, (ctrl == 8'h00) ? 8'h01 : ctrl, 1'b0, 1'b1, 1'b1);
				2: send_word({{4{8'h07}}, 8'h55, {3{8'h07}}}, 8'hFF, 1'b0, 1'b1, 1'b1);
				default: send_word(data, 8'h00, 1'b0, 1'b1, 1'b1);
			endcase
		end

		// Alignment tags in the stream
		repeat (30)
			send_word(random_word(), ($random(seed) & 1) ? 8'h00 : 8'hFF,
				($random(seed) & 1) != 0, 1'b1, 1'b1);
		drain();
		i_bypass = 1'b1;
		repeat (10) send_word(random_word(), random_flags(), 1'b0, 1'b1, 1'b1);
		drain();
		i_bypass = 1'b0;
		repeat (10) send_word(random_word(), 8'h00, 1'b0, 1'b1, 1'b1);
		drain();

		// Idle-pattern mode ignores the input
		i_idle_pattern_mode = 1'b1;
		repeat (20) send_word(random_word(), random_flags(), 1'b0, 1'b1, 1'b1);
		drain();
		i_idle_pattern_mode = 1'b0;

		// Gaps from i_enable and i_valid
		repeat (60)
			send_word(random_word(), ($random(seed) & 1) ? 8'h00 : 8'hFF, 1'b0,
				($random(seed) & 3) != 0, ($random(seed) & 3) != 0);
		drain();

		// Mid-stream reset brings the seed back
		hold_reset(4);
		repeat (20) send_word(random_word(), 8'h00, 1'b0, 1'b1, 1'b1);
		drain();

		if (u_monitor.checked_count == 0)
		begin
			$display("no output block was ever checked");
			timeout_count++;
		end
		total_errors = u_monitor.error_count + timeout_count
			+ UUT.u_scrambler.u_checker.fail_count;
		$display("Summary: %0d checked, %0d mismatches, %0d timeouts, %0d assert fails",
			u_monitor.checked_count, u_monitor.error_count, timeout_count,
			UUT.u_scrambler.u_checker.fail_count);
		if (total_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+common
common/pcs_pkg.sv
source/pcs_encoder.sv
scrambler/scrambler.sv
source/pcs_tx.sv
verification/pcs_tx_checker.sv
verification/pcs_tx_monitor.sv
verification/tb_pcs_tx.sv

// File: Bender.yml
package:
  name: pcs_tx

# pcs_consts.svh lives here
export_include_dirs:
  - common

sources:
  # Shared types
  - common/pcs_pkg.sv

  # Design
  - source/pcs_encoder.sv
  - scrambler/scrambler.sv
  - source/pcs_tx.sv

  # Testbench
  - target: test
    files:
      - verification/pcs_tx_checker.sv
      - verification/pcs_tx_monitor.sv
      - verification/tb_pcs_tx.sv
